/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tryPadTb
FILELIST = vlog.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tbClockGen.sv */
// Testbench clock and power-on reset source for the control core
module tbClockGen
(
	output logic iMCLK,
	output logic qnARST
);
	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period, reset held for five periods
	localparam int lpPeriodNs = 8;
	localparam int lpResetCycles = 5;

	initial
	begin
		iMCLK = 1'b0;
		forever
			#(lpPeriodNs / 2) iMCLK = ~iMCLK;
	end

	// Release lands on a falling edge
	initial
	begin
		qnARST = 1'b0;
		#(lpPeriodNs * lpResetCycles);
		qnARST = 1'b1;
	end

endmodule

/* bench/tryPadStim.txt */
# name op addr data expect, all numbers hex
# ops WR RD CNT(data=tolerance) SW PLL WAIT(data=cycles) PO(expect=padOe)
po_reset PO 0 0 0
id_read RD 0000000c 0 00015044
padoe_wr WR 00000008 a5c3 0
padoe_rd RD 00000008 0 0000a5c3
padoe_pin PO 0 0 a5c3
sw_set SW 0 a5c 0
pll_set PLL 0 5 0
sw_wait WAIT 0 4 0
swstate_rd RD 00000000 0 00050a5c
sw_release SW 0 0 0
sw_settle WAIT 0 4 0
edge_clr_all WR 00000004 fff 0
edge_empty RD 00000004 0 0
press_a SW 0 005 0
press_a_wait WAIT 0 4 0
press_b SW 0 00f 0
press_b_wait WAIT 0 4 0
edge_rd RD 00000004 0 0000000f
edge_clr_part WR 00000004 005 0
edge_part_rd RD 00000004 0 0000000a
unmap_rd RD 00020000 0 0
unmap_wr_oe WR 00020008 1234 0
unmap_wr_tim WR 00020004 5555 0
unmap_oe_rd RD 00000008 0 0000a5c3
unmap_tim_rd RD 00040004 0 0
unmap_pin PO 0 0 a5c3
tim_reload WR 00040004 9 0
tim_enable WR 00040000 1 0
tim_run WAIT 0 c8 0
tim_disable WR 00040000 0 0
tim_count CNT 00040008 1 14
tim_clear WR 00040008 0 0
tim_clear_rd RD 00040008 0 0

/* bench/tryPadTb.sv */
// Testbench that runs the stimulus table against the control core over its register bus
module tryPadTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int lpMaxLines = 64;
	// Cycles allowed for one ack
	localparam int lpAckLimit = 16;
	// Watchdog share of each table line
	localparam int lpLineBudget = 20;
	localparam int lpResetCycles = 5;

	logic iMCLK;
	logic qnARST;
	tryPadPkg::usiReqT usiReq;
	tryPadPkg::usiRspT usiRsp;
	logic [tryPadPkg::lpExtSwNum-1:0] pushSw;
	logic [tryPadPkg::lpPllNum-1:0] pllLock;
	logic [tryPadPkg::lpPadOeWidth-1:0] padOe;
	logic tick;

	// Stimulus table
	string testName [lpMaxLines];
	string testOp [lpMaxLines];
	logic [31:0] testAdr [lpMaxLines];
	logic [31:0] testDat [lpMaxLines];
	logic [31:0] testExp [lpMaxLines];
	int lineCnt;
	int watchCycles;
	int passCnt;
	int failCnt;
	bit ackInReset;
	bit lineOk;
	// Tick pulses seen on the pin since reset
	logic [31:0] tickTally;

	tbClockGen uClockGen
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST)
	);

	tryPadTop uut
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST),
		.usiReq (usiReq),
		.usiRsp (usiRsp),
		.pushSw (pushSw),
		.pllLock (pllLock),
		.padOe (padOe),
		.tick (tick)
	);

	// ------------------------------
	// Stimulus loading
	// ------------------------------
	task automatic loadStim();
		int fd;
		int fields;
		string line;
		string nameS;
		string opS;
		logic [31:0] adrV;
		logic [31:0] datV;
		logic [31:0] expV;
		fd = $fopen("bench/tryPadStim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file bench/tryPadStim.txt");
			failCnt++;
			return;
		end
		while (!$feof(fd) && lineCnt < lpMaxLines)
		begin
			line = "";
			fields = $fgets(line, fd);
			// Hash starts a comment line
			if (line.len() > 0 && line.getc(0) != 8'h23)
			begin
				fields = $sscanf(line, "%s %s %h %h %h", nameS, opS, adrV, datV, expV);
				if (fields == 5)
				begin
					testName[lineCnt] = nameS;
					testOp[lineCnt] = opS;
					testAdr[lineCnt] = adrV;
					testDat[lineCnt] = datV;
					testExp[lineCnt] = expV;
					lineCnt++;
				end
			end
		end
		$fclose(fd);
	endtask

	// One Wishbone classic transfer, held until ack
	task automatic busXfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
		output tryPadPkg::usiRspT rsp, output bit gotAck);
		int waitCnt;
		gotAck = 1'b0;
		rsp = '0;
		waitCnt = 0;
		@(posedge iMCLK);
		usiReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: dat};
		// Ack sampled mid-cycle
		while (!gotAck && waitCnt < lpAckLimit)
		begin
			@(negedge iMCLK);
			waitCnt++;
			if (usiRsp.ack === 1'b1)
			begin
				gotAck = 1'b1;
				rsp = usiRsp;
			end
		end
		// Strobe drops in the cycle after ack
		@(posedge iMCLK);
		usiReq <= '0;
	endtask

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkRsp(input string name, input logic [31:0] exp,
		input tryPadPkg::usiRspT rsp);
		if (rsp.datR !== exp)
		begin
			$display("[FAIL] %s expected %08h actual %08h", name, exp, rsp.datR);
			lineOk = 1'b0;
		end
	endtask

	task automatic checkPadOe(input string name,
		input logic [tryPadPkg::lpPadOeWidth-1:0] exp,
		input logic [tryPadPkg::lpPadOeWidth-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %04h actual %04h", name, exp, act);
			lineOk = 1'b0;
		end
	endtask

	// Count within exp +/- tol
	task automatic checkCount(input string name, input logic [31:0] exp, input logic [31:0] tol,
		input tryPadPkg::usiRspT rsp);
		if ($isunknown(rsp.datR) || rsp.datR > exp + tol || rsp.datR + tol < exp)
		begin
			$display("[FAIL] %s expected %0d +/- %0d actual %0d", name, exp, tol, rsp.datR);
			lineOk = 1'b0;
		end
	endtask

	// Pulses on the tick pin within exp +/- tol
	task automatic checkTicks(input string name, input logic [31:0] exp, input logic [31:0] tol,
		input logic [31:0] act);
		if (act > exp + tol || act + tol < exp)
		begin
			$display("[FAIL] %s tick pin expected %0d +/- %0d actual %0d", name, exp, tol,
				act);
			lineOk = 1'b0;
		end
	endtask

	task automatic reportNoAck(input string name);
		$display("%s: the DUT did not acknowledge the transfer within %0d cycles",
			name, lpAckLimit);
		lineOk = 1'b0;
	endtask

	// ------------------------------
	// Table line execution
	// ------------------------------
	task automatic runLine(input int idx);
		tryPadPkg::usiRspT rsp;
		bit gotAck;
		lineOk = 1'b1;
		case (testOp[idx])
			"WR":
			begin
				busXfer(1'b1, testAdr[idx], testDat[idx], rsp, gotAck);
				if (!gotAck)
					reportNoAck(testName[idx]);
			end
			"RD":
			begin
				busXfer(1'b0, testAdr[idx], '0, rsp, gotAck);
				if (!gotAck)
					reportNoAck(testName[idx]);
				else
					checkRsp(testName[idx], testExp[idx], rsp);
			end
			"CNT":
			begin
				// Data column holds the tolerance
				busXfer(1'b0, testAdr[idx], '0, rsp, gotAck);
				if (!gotAck)
					reportNoAck(testName[idx]);
				else
					checkCount(testName[idx], testExp[idx], testDat[idx], rsp);
				checkTicks(testName[idx], testExp[idx], testDat[idx], tickTally);
			end
			"SW":
			begin
				@(posedge iMCLK);
				pushSw <= testDat[idx][tryPadPkg::lpExtSwNum-1:0];
			end
			"PLL":
			begin
				@(posedge iMCLK);
				pllLock <= testDat[idx][tryPadPkg::lpPllNum-1:0];
			end
			"WAIT":
				repeat (testDat[idx]) @(posedge iMCLK);
			"PO":
			begin
				@(negedge iMCLK);
				checkPadOe(testName[idx], testExp[idx][tryPadPkg::lpPadOeWidth-1:0], padOe);
			end
			default:
			begin
				$display("%s: unknown operation %s in the stimulus file", testName[idx],
					testOp[idx]);
				lineOk = 1'b0;
			end
		endcase
		if (lineOk)
		begin
			passCnt++;
			$display("[PASS] %s", testName[idx]);
		end
		else
			failCnt++;
	endtask

	// Ack must stay low through reset
	always @(negedge iMCLK)
	begin
		if (qnARST !== 1'b1 && usiRsp.ack !== 1'b0)
			ackInReset = 1'b1;
	end

	// One count per single-cycle tick pulse
	always @(negedge iMCLK)
	begin
		if (qnARST === 1'b1 && tick === 1'b1)
			tickTally++;
	end

	// Watchdog sized from the table
	initial
	begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge iMCLK);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		int total;
		usiReq = '0;
		pushSw = '0;
		pllLock = '0;
		passCnt = 0;
		failCnt = 0;
		lineCnt = 0;
		watchCycles = 0;
		ackInReset = 1'b0;
		tickTally = '0;
		loadStim();
		total = lpResetCycles + lpLineBudget * lineCnt;
		for (int i = 0; i < lineCnt; i++)
		begin
			if (testOp[i] == "WAIT")
				total += int'(testDat[i]);
		end
		watchCycles = total;
		if (lineCnt == 0)
		begin
			$display("The stimulus table holds no tests");
			failCnt++;
		end
		@(posedge qnARST);
		@(posedge iMCLK);
		if (ackInReset)
		begin
			$display("The DUT raised ack while reset was asserted");
			failCnt++;
		end
		else
		begin
			passCnt++;
			$display("[PASS] reset_ack");
		end
		for (int i = 0; i < lineCnt; i++)
			runLine(i);
		$display("Tests passed: %0d, failed: %0d", passCnt, failCnt);
		if (failCnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* common/tryPadPkg.sv */
// Shared constants, block map, register offsets and bus structs of the console control core
package tryPadPkg;

	// ------------------------------
	// Bus geometry
	// ------------------------------
	// Data and address width of the register bus
	localparam int lpUsiBusWidth = 32;
	// Block number field inside the bus address
	localparam int lpBlockAdrsWidth = 3;
	localparam int lpBlockLsb = 16;
	// Offset bits seen by every register block
	localparam int lpCsrActiveWidth = 8;

	// Block map
	localparam logic [lpBlockAdrsWidth-1:0] lpGpioAdrsMap = 3'd0;
	localparam logic [lpBlockAdrsWidth-1:0] lpSysTimerAdrsMap = 3'd4;

	// ------------------------------
	// Board resources
	// ------------------------------
	localparam int lpExtSwNum = 12;
	localparam int lpPllNum = 3;
	// Video 7..0, audio 10..8, ROM 15..11
	localparam int lpPadOeWidth = 16;

	// Identification
	localparam logic [15:0] lpSystemVersion = 16'h0001;
	localparam logic [31:0] lpCustomCode = "TRPD";

	// GPIO register offsets
	localparam logic [lpCsrActiveWidth-1:0] lpGpioSwStateOfs = 8'h00;
	localparam logic [lpCsrActiveWidth-1:0] lpGpioSwEdgeOfs = 8'h04;
	localparam logic [lpCsrActiveWidth-1:0] lpGpioPadOeOfs = 8'h08;
	localparam logic [lpCsrActiveWidth-1:0] lpGpioIdOfs = 8'h0C;

	// Timer register offsets
	localparam logic [lpCsrActiveWidth-1:0] lpTimCtrlOfs = 8'h00;
	localparam logic [lpCsrActiveWidth-1:0] lpTimReloadOfs = 8'h04;
	localparam logic [lpCsrActiveWidth-1:0] lpTimCountOfs = 8'h08;

	// ------------------------------
	// Bus structs
	// ------------------------------
	// Host request, Wishbone classic style
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [lpUsiBusWidth-1:0] adr;
		logic [lpUsiBusWidth-1:0] datW;
	} usiReqT;

	// Host response
	typedef struct packed {
		logic ack;
		logic [lpUsiBusWidth-1:0] datR;
	} usiRspT;

	// Register access toward one block
	typedef struct packed {
		logic sel;
		logic we;
		logic [lpCsrActiveWidth-1:0] ofs;
		logic [lpUsiBusWidth-1:0] wd;
	} csrReqT;

endpackage

/* gpio/gpioCsr.sv */
// GPIO register block with pad output enables, switch status, press latches and ID word
module gpioCsr
(
	input logic iMCLK,
	input logic qnARST,
	input tryPadPkg::csrReqT csrReq,
	output logic [tryPadPkg::lpUsiBusWidth-1:0] csrRd,
	input logic [tryPadPkg::lpExtSwNum-1:0] pushSw,
	input logic [tryPadPkg::lpPllNum-1:0] pllLock,
	output logic [tryPadPkg::lpPadOeWidth-1:0] padOe
);

	logic [tryPadPkg::lpExtSwNum-1:0] swLevel;
	logic [tryPadPkg::lpExtSwNum-1:0] swPress;
	logic [tryPadPkg::lpExtSwNum-1:0] swEdge;
	logic [tryPadPkg::lpExtSwNum-1:0] edgeClr;
	logic [tryPadPkg::lpPllNum-1:0] pllSyncA;
	logic [tryPadPkg::lpPllNum-1:0] pllSyncB;
	logic csrWr;

	// Switch synchronizer and press detect
	switchSampler uSwitchSampler
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST),
		.pushSw (pushSw),
		.swLevel (swLevel),
		.swPress (swPress)
	);

	assign csrWr = csrReq.sel & csrReq.we;
	// Write one to clear
	assign edgeClr = (csrWr && (csrReq.ofs == tryPadPkg::lpGpioSwEdgeOfs)) ?
		csrReq.wd[tryPadPkg::lpExtSwNum-1:0] : '0;

	// ------------------------------
	// Control registers
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			padOe <= '0;
			swEdge <= '0;
			pllSyncA <= '0;
			pllSyncB <= '0;
		end
		else
		begin
			// Every pad starts as input
			if (csrWr && (csrReq.ofs == tryPadPkg::lpGpioPadOeOfs))
				padOe <= csrReq.wd[tryPadPkg::lpPadOeWidth-1:0];
			// New press beats a clear in the same cycle
			swEdge <= (swEdge & ~edgeClr) | swPress;
			// Lock inputs come from other clock sources
			pllSyncA <= pllLock;
			pllSyncB <= pllSyncA;
		end
	end

	// Read words
	always_comb
	begin
		case (csrReq.ofs)
			tryPadPkg::lpGpioSwStateOfs: csrRd = {13'd0, pllSyncB, 4'd0, swLevel};
			tryPadPkg::lpGpioSwEdgeOfs: csrRd = {20'd0, swEdge};
			tryPadPkg::lpGpioPadOeOfs: csrRd = {16'd0, padOe};
			tryPadPkg::lpGpioIdOfs: csrRd = {tryPadPkg::lpSystemVersion,
				tryPadPkg::lpCustomCode[15:0]};
			default: csrRd = '0;
		endcase
	end

endmodule

/* gpio/switchSampler.sv */
// Push switch synchronizer with rising-edge press detection
module switchSampler
(
	input logic iMCLK,
	input logic qnARST,
	input logic [tryPadPkg::lpExtSwNum-1:0] pushSw,
	output logic [tryPadPkg::lpExtSwNum-1:0] swLevel,
	output logic [tryPadPkg::lpExtSwNum-1:0] swPress
);

	// Two sync stages then history
	logic [tryPadPkg::lpExtSwNum-1:0] syncA;
	logic [tryPadPkg::lpExtSwNum-1:0] syncB;
	logic [tryPadPkg::lpExtSwNum-1:0] prevLevel;

	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			syncA <= '0;
			syncB <= '0;
			prevLevel <= '0;
		end
		else
		begin
			syncA <= pushSw;
			syncB <= syncA;
			// Last cycle's level for edge detect
			prevLevel <= syncB;
		end
	end

	// Sampled level, two cycles behind the pin
	assign swLevel = syncB;
	// One-cycle pulse on a new press
	assign swPress = syncB & ~prevLevel;

endmodule

/* hdl/tryPadTop.sv */
// Control core top level joining the bus decoder, GPIO block and tick timer
module tryPadTop
(
	input logic iMCLK,
	input logic qnARST,
	input tryPadPkg::usiReqT usiReq,
	output tryPadPkg::usiRspT usiRsp,
	input logic [tryPadPkg::lpExtSwNum-1:0] pushSw,
	input logic [tryPadPkg::lpPllNum-1:0] pllLock,
	output logic [tryPadPkg::lpPadOeWidth-1:0] padOe,
	output logic tick
);

	// Decoder to block requests
	tryPadPkg::csrReqT gpioReq;
	tryPadPkg::csrReqT timReq;
	// Block read words
	logic [tryPadPkg::lpUsiBusWidth-1:0] gpioRd;
	logic [tryPadPkg::lpUsiBusWidth-1:0] timRd;

	// ------------------------------
	// Register bus
	// ------------------------------
	usiBusDecoder uUsiBusDecoder
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST),
		.usiReq (usiReq),
		.usiRsp (usiRsp),
		.gpioReq (gpioReq),
		.timReq (timReq),
		.gpioRd (gpioRd),
		.timRd (timRd)
	);

	// ------------------------------
	// Register blocks
	// ------------------------------
	gpioCsr uGpioCsr
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST),
		.csrReq (gpioReq),
		.csrRd (gpioRd),
		.pushSw (pushSw),
		.pllLock (pllLock),
		.padOe (padOe)
	);

	sysTickTimer uSysTickTimer
	(
		.iMCLK (iMCLK),
		.qnARST (qnARST),
		.csrReq (timReq),
		.csrRd (timRd),
		.tick (tick)
	);

endmodule

/* hdl/usiBusDecoder.sv */
// Register bus slave that picks the target block and returns its read word with ack
module usiBusDecoder
(
	input logic iMCLK,
	input logic qnARST,
	input tryPadPkg::usiReqT usiReq,
	output tryPadPkg::usiRspT usiRsp,
	output tryPadPkg::csrReqT gpioReq,
	output tryPadPkg::csrReqT timReq,
	input logic [tryPadPkg::lpUsiBusWidth-1:0] gpioRd,
	input logic [tryPadPkg::lpUsiBusWidth-1:0] timRd
);

	logic [tryPadPkg::lpBlockAdrsWidth-1:0] blockNum;
	logic [tryPadPkg::lpUsiBusWidth-1:0] rdMux;
	logic [tryPadPkg::lpUsiBusWidth-1:0] rdQ;
	logic ackQ;
	logic newReq;

	// Block field out of the address
	assign blockNum = usiReq.adr[tryPadPkg::lpBlockLsb +: tryPadPkg::lpBlockAdrsWidth];
	// New transfer only while ack is low
	assign newReq = usiReq.cyc & usiReq.stb & ~ackQ;

	// Per-block request, sel pulses only at the target
	assign gpioReq = '{sel: newReq && (blockNum == tryPadPkg::lpGpioAdrsMap),
		we: usiReq.we, ofs: usiReq.adr[tryPadPkg::lpCsrActiveWidth-1:0], wd: usiReq.datW};
	assign timReq = '{sel: newReq && (blockNum == tryPadPkg::lpSysTimerAdrsMap),
		we: usiReq.we, ofs: usiReq.adr[tryPadPkg::lpCsrActiveWidth-1:0], wd: usiReq.datW};

	// Read word select, unmapped blocks read zero
	always_comb
	begin
		case (blockNum)
			tryPadPkg::lpGpioAdrsMap: rdMux = gpioRd;
			tryPadPkg::lpSysTimerAdrsMap: rdMux = timRd;
			default: rdMux = '0;
		endcase
	end

	// One-cycle ack
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
			ackQ <= 1'b0;
		else
			ackQ <= newReq;
	end

	// Read data captured alongside ack
	always_ff @(posedge iMCLK)
	begin
		if (newReq)
			rdQ <= rdMux;
	end

	assign usiRsp = '{ack: ackQ, datR: rdQ};

	// Host must still hold the cycle when ack arrives
	ackInCycle: assert property (@(posedge iMCLK) disable iff (!qnARST)
		ackQ |-> usiReq.cyc && usiReq.stb);
	// Ack is a single-cycle pulse
	ackOneCycle: assert property (@(posedge iMCLK) disable iff (!qnARST)
		ackQ |=> !ackQ);

endmodule

/* timer/sysTickTimer.sv */
// System tick timer with reload divider, tick counter and control registers
module sysTickTimer
(
	input logic iMCLK,
	input logic qnARST,
	input tryPadPkg::csrReqT csrReq,
	output logic [tryPadPkg::lpUsiBusWidth-1:0] csrRd,
	output logic tick
);

	logic enable;
	logic [15:0] reload;
	logic [15:0] divCnt;
	logic [tryPadPkg::lpUsiBusWidth-1:0] count;
	logic csrWr;
	logic reloadWr;
	logic countClr;

	assign csrWr = csrReq.sel & csrReq.we;
	assign reloadWr = csrWr && (csrReq.ofs == tryPadPkg::lpTimReloadOfs);
	// Any write to COUNT clears it
	assign countClr = csrWr && (csrReq.ofs == tryPadPkg::lpTimCountOfs);

	// Tick once per reload+1 cycles
	assign tick = enable && (divCnt == reload);

	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			enable <= 1'b0;
			reload <= '0;
			divCnt <= '0;
			count <= '0;
		end
		else
		begin
			if (csrWr && (csrReq.ofs == tryPadPkg::lpTimCtrlOfs))
				enable <= csrReq.wd[0];
			if (reloadWr)
				reload <= csrReq.wd[15:0];
			// Divider restarts on a reload write, holds while disabled
			if (reloadWr || tick)
				divCnt <= '0;
			else if (enable)
				divCnt <= divCnt + 16'd1;
			if (countClr)
				count <= '0;
			else if (tick)
				count <= count + 1'b1;
		end
	end

	always_comb
	begin
		case (csrReq.ofs)
			tryPadPkg::lpTimCtrlOfs: csrRd = {31'd0, enable};
			tryPadPkg::lpTimReloadOfs: csrRd = {16'd0, reload};
			tryPadPkg::lpTimCountOfs: csrRd = count;
			default: csrRd = '0;
		endcase
	end

	// No tick while stopped
	noTickDisabled: assert property (@(posedge iMCLK) disable iff (!qnARST)
		!enable |-> !tick);

endmodule

/* vlog.f */
common/tryPadPkg.sv
gpio/switchSampler.sv
gpio/gpioCsr.sv
timer/sysTickTimer.sv
hdl/usiBusDecoder.sv
hdl/tryPadTop.sv
bench/tbClockGen.sv
bench/tryPadTb.sv
